// File: masked_alu.f
src/masked_alu_pkg.sv
src/prng_lfsr.sv
src/masked_logic.sv
src/masked_adder.sv
src/masked_shifter.sv
src/mask_refresh.sv
src/masked_alu_ctl.sv
src/masked_alu.sv
test/masked_alu_properties.sv
test/tb_masked_alu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the masked ALU testbench with Verilator, pass only if the log says so
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_masked_alu -f masked_alu.f -o sim_masked_alu

# Keep running after the first assertion error so the testbench prints its report
./obj_dir/sim_masked_alu +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

grep -q "Test completed successfully" sim.log

// File: test/tb_masked_alu.sv
// Testbench for the masked ALU: random shared operands for every opcode, checked on plain values
`timescale 1ns/10ps
module tb_masked_alu;
  import masked_alu_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_OPS      = 40;
  localparam int OP_CYCLES    = 10;   // Worst case per operation, idle cycle included

  logic        g_clk;
  logic        g_resetn;
  logic        i_valid;
  alu_op_e     i_op;
  share_pair_t i_rs1;
  share_pair_t i_rs2;
  logic        o_ready;
  share_pair_t o_rd;
  word_t       o_mask;

  int seed;
  int errors;
  int checks;

  masked_alu dut (.*);

  initial begin
    g_clk = 1'b0;
    forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
  end

  initial begin
    #((NUM_OPS * OP_CYCLES + RESET_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired before all operations finished");
    $display("Test failed");
    $finish;
  end

  // Plain result from the recombined operands
  function automatic word_t ref_result(alu_op_e op, share_pair_t r1, share_pair_t r2);
    word_t              a;
    word_t              b;
    logic [SHAMT_W-1:0] n;
    logic [2*XLEN-1:0]  dbl;
    a   = r1.s0 ^ r1.s1;
    b   = r2.s0 ^ r2.s1;
    n   = r2.s0[SHAMT_W-1:0];   // Shift amount is not masked
    dbl = {a, a} >> n;
    case (op)
      OP_NOT:  return ~a;
      OP_XOR:  return a ^ b;
      OP_AND:  return a & b;
      OP_IOR:  return a | b;
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_SRL:  return a >> n;
      OP_SLL:  return a << n;
      OP_ROR:  return dbl[XLEN-1:0];
      OP_BMASK: return r1.s0;
      default: return a;
    endcase
  endfunction

  task automatic check_value(string name, word_t exp, word_t got);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // Hold one request until o_ready, then drop i_valid for a cycle
  task automatic run_op(alu_op_e op);
    share_pair_t rs1;
    share_pair_t rs2;
    rs1 = {$random(seed), $random(seed)};
    rs2 = {$random(seed), $random(seed)};
    @(posedge g_clk);
    #2;
    i_valid = 1'b1;
    i_op    = op;
    i_rs1   = rs1;
    i_rs2   = rs2;
    @(negedge g_clk);
    while (!o_ready) @(negedge g_clk);
    check_value($sformatf("o_rd (%s)", op.name()), ref_result(op, rs1, rs2), o_rd.s0 ^ o_rd.s1);
    if (op == OP_BMASK || op == OP_BREMASK) begin
      check_value("o_rd.s1", o_mask, o_rd.s1);
    end
    @(posedge g_clk);
    #2;
    i_valid = 1'b0;
  endtask

  initial begin
    seed     = 32'h3d381b83;
    errors   = 0;
    checks   = 0;
    g_resetn = 1'b0;
    i_valid  = 1'b0;
    i_op     = OP_NOT;
    i_rs1    = '0;
    i_rs2    = '0;
    repeat (RESET_CYCLES) @(posedge g_clk);
    #2;
    g_resetn = 1'b1;
    for (int i = 0; i < NUM_OPS; i++) begin
      run_op(alu_op_e'(i % 11));   // Walk all eleven opcodes in turn
    end
    $display("Checks: %0d, data errors: %0d, property failures: %0d",
             checks, errors, dut.props.fail_count);
    if (errors == 0 && dut.props.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: test/masked_alu_properties.sv
// Latency, reset and LFSR stepping assertions for the masked ALU, bound into every masked_alu
`timescale 1ns/10ps
module masked_alu_props (
  input  logic                       g_clk,
  input  logic                       g_resetn,
  input  logic                       i_valid,
  input  masked_alu_pkg::alu_op_e    i_op,
  input  logic                       i_ready,
  input  masked_alu_pkg::word_t      i_mask,
  input  masked_alu_pkg::ctl_state_e i_state
);
  import masked_alu_pkg::*;

  logic [3:0] wait_q;       // Cycles since the request started
  int         fail_count;   // Read by the testbench for its closing report

  function automatic logic [3:0] op_latency(alu_op_e op);
    case (op)
      OP_NOT, OP_SRL, OP_SLL, OP_ROR: return 4'd0;
      OP_ADD, OP_SUB:                 return 4'(ADD_STEPS + 1);
      default:                        return 4'd1;   // Logic stage and mask unit
    endcase
  endfunction

  always_ff @(posedge g_clk) begin
    if (!g_resetn || !i_valid || i_ready) begin
      wait_q <= '0;
    end else begin
      wait_q <= wait_q + 4'd1;
    end
  end

  initial fail_count = 0;

  ready_on_time: assert property (@(posedge g_clk) disable iff (!g_resetn)
    i_ready |-> (wait_q == op_latency(i_op)))
    else begin
      fail_count++;
      $error("o_ready after %0d cycles for %s", wait_q, i_op.name());
    end

  ready_not_late: assert property (@(posedge g_clk) disable iff (!g_resetn)
    (i_valid && !i_ready) |-> (wait_q < op_latency(i_op)))
    else begin
      fail_count++;
      $error("o_ready still low after %0d cycles for %s", wait_q, i_op.name());
    end

  // First cycle out of reset
  reset_state: assert property (@(posedge g_clk)
    $rose(g_resetn) |-> (!i_ready && (i_mask == LFSR_SEED) && (i_state == ST_IDLE)))
    else begin
      fail_count++;
      $error("Bad state after reset, o_mask %h", i_mask);
    end

  mask_steps: assert property (@(posedge g_clk) disable iff (!g_resetn)
    i_ready |=> (i_mask != $past(i_mask)))
    else begin
      fail_count++;
      $error("o_mask did not advance after a result");
    end

endmodule

bind masked_alu masked_alu_props props (
  .g_clk, .g_resetn, .i_valid, .i_op, .i_ready(o_ready), .i_mask(o_mask),
  .i_state(u_ctl.state_q)
);

// File: src/masked_alu.sv
// Two-share Boolean masked ALU top: operand selection, unit wiring and result merge
`timescale 1ns/10ps
module masked_alu (
  input  logic                        g_clk,
  input  logic                        g_resetn,
  input  logic                        i_valid,
  input  masked_alu_pkg::alu_op_e     i_op,
  input  masked_alu_pkg::share_pair_t i_rs1,
  input  masked_alu_pkg::share_pair_t i_rs2,
  output logic                        o_ready,
  output masked_alu_pkg::share_pair_t o_rd,
  output masked_alu_pkg::word_t       o_mask
);
  import masked_alu_pkg::*;

  logic        op_not, op_xor, op_and, op_ior, op_sub;
  logic        op_logic, op_arith, op_shift, op_msk;
  logic        logic_en, logic_ready, adder_en, adder_done, msk_done;
  word_t       lfsr_q, lfsr_next, lg_fresh;
  share_pair_t op_a, op_b, lg_xor, lg_and, add_and, add_sum, shf, msk_rd;

  assign op_not   = (i_op == OP_NOT);
  assign op_xor   = (i_op == OP_XOR);
  assign op_and   = (i_op == OP_AND);
  assign op_ior   = (i_op == OP_IOR);
  assign op_sub   = (i_op == OP_SUB);
  assign op_logic = op_xor || op_and || op_ior;
  assign op_arith = (i_op == OP_ADD) || op_sub;
  assign op_shift = (i_op == OP_SRL) || (i_op == OP_SLL) || (i_op == OP_ROR);
  assign op_msk   = (i_op == OP_BMASK) || (i_op == OP_BREMASK);

  prng_lfsr u_prng (.g_clk, .g_resetn, .i_step(o_ready), .o_value(lfsr_q), .o_next(lfsr_next));

  // OR via De Morgan, SUB adds the inverted rs2
  assign op_a.s0 = i_rs1.s0;
  assign op_a.s1 = op_ior ? ~i_rs1.s1 : i_rs1.s1;
  assign op_b.s0 = i_rs2.s0;
  assign op_b.s1 = (op_ior || op_sub) ? ~i_rs2.s1 : i_rs2.s1;

  masked_logic u_logic (
    .g_clk, .g_resetn, .i_en(logic_en), .i_fresh(lfsr_next), .i_a(op_a), .i_b(op_b),
    .o_xor(lg_xor), .o_and(lg_and), .o_fresh(lg_fresh), .o_ready(logic_ready)
  );

  masked_alu_ctl u_ctl (
    .g_clk, .g_resetn, .i_valid, .i_logic_op(op_logic), .i_arith_op(op_arith),
    .i_logic_ready(logic_ready), .i_adder_done(adder_done),
    .o_logic_en(logic_en), .o_adder_en(adder_en)
  );

  // Carry-in of one folded into generate bit 0 for subtraction
  assign add_and.s0 = {lg_and.s0[XLEN-1:1], lg_and.s0[0] ^ (lg_xor.s0[0] & op_sub)};
  assign add_and.s1 = {lg_and.s1[XLEN-1:1], lg_and.s1[0] ^ (lg_xor.s1[0] & op_sub)};

  masked_adder u_adder (
    .g_clk, .g_resetn, .i_en(adder_en), .i_sub(op_sub), .i_fresh(lg_fresh),
    .i_xor(lg_xor), .i_and(add_and), .o_sum(add_sum), .o_done(adder_done)
  );

  masked_shifter u_shift0 (.i_share(i_rs1.s0), .i_shamt(i_rs2.s0[SHAMT_W-1:0]), .i_pad(lfsr_q),
                           .i_op, .o_share(shf.s0));
  masked_shifter u_shift1 (.i_share(i_rs1.s1), .i_shamt(i_rs2.s0[SHAMT_W-1:0]), .i_pad(lfsr_q),
                           .i_op, .o_share(shf.s1));

  mask_refresh u_refresh (
    .g_clk, .g_resetn, .i_start(i_valid && op_msk), .i_remask(i_op == OP_BREMASK),
    .i_rs1, .i_rand(lfsr_q), .o_rd(msk_rd), .o_done(msk_done)
  );

  // One-hot merge, NOT and XOR get refreshed with the next LFSR word
  assign o_rd.s0 = ({XLEN{op_not}} & (lfsr_next ^ i_rs1.s0)) |
                   ({XLEN{op_xor}} & (lfsr_next ^ lg_xor.s0)) |
                   ({XLEN{op_and || op_ior}} & lg_and.s0) |
                   ({XLEN{op_shift}} & shf.s0) |
                   ({XLEN{op_arith}} & add_sum.s0) |
                   ({XLEN{op_msk}} & msk_rd.s0);
  assign o_rd.s1 = ({XLEN{op_not}} & (lfsr_next ^ ~i_rs1.s1)) |
                   ({XLEN{op_xor}} & (lfsr_next ^ lg_xor.s1)) |
                   ({XLEN{op_and}} & lg_and.s1) |
                   ({XLEN{op_ior}} & ~lg_and.s1) |
                   ({XLEN{op_shift}} & shf.s1) |
                   ({XLEN{op_arith}} & add_sum.s1) |
                   ({XLEN{op_msk}} & msk_rd.s1);

  assign o_ready = i_valid && (op_not || op_shift || (op_logic && logic_ready) ||
                               (op_arith && adder_done) || (op_msk && msk_done));
  assign o_mask  = lfsr_q;

endmodule

// File: src/masked_alu_ctl.sv
// FSM sequencing the masked logic stage and the iterative adder for one operation at a time
`timescale 1ns/10ps
module masked_alu_ctl (
  input  logic g_clk,
  input  logic g_resetn,
  input  logic i_valid,
  input  logic i_logic_op,
  input  logic i_arith_op,
  input  logic i_logic_ready,
  input  logic i_adder_done,
  output logic o_logic_en,
  output logic o_adder_en
);
  import masked_alu_pkg::*;

  ctl_state_e state_q;
  logic       logic_go;
  logic       arith_go;

  assign logic_go = i_valid && (i_logic_op || i_arith_op);   // Add/sub also need the logic stage
  assign arith_go = i_valid && i_arith_op;

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:  if (logic_go) state_q <= ST_LOGIC;
        ST_LOGIC: if (i_logic_ready) state_q <= arith_go ? ST_ARITH : ST_IDLE;
        ST_ARITH: if (i_adder_done) state_q <= ST_IDLE;
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

  assign o_logic_en = logic_go && (state_q == ST_IDLE);
  assign o_adder_en = arith_go && (((state_q == ST_LOGIC) && i_logic_ready) ||
                                   (state_q == ST_ARITH));

endmodule

// File: src/mask_refresh.sv
// Boolean mask and remask unit, registers the blinded share and flags done one cycle later
`timescale 1ns/10ps
module mask_refresh (
  input  logic                        g_clk,
  input  logic                        g_resetn,
  input  logic                        i_start,
  input  logic                        i_remask,
  input  masked_alu_pkg::share_pair_t i_rs1,
  input  masked_alu_pkg::word_t       i_rand,
  output masked_alu_pkg::share_pair_t o_rd,
  output logic                        o_done
);
  import masked_alu_pkg::*;

  word_t blind_q;   // rs1 share 0 under the current LFSR word
  logic  done_q;

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      blind_q <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= i_start && !done_q;   // Single pulse per request
      if (i_start && !done_q) begin
        blind_q <= i_rs1.s0 ^ i_rand;
      end
    end
  end

  // Remask folds in the old share 1, the new share 1 is the LFSR word itself
  assign o_rd.s0 = i_remask ? (blind_q ^ i_rs1.s1) : blind_q;
  assign o_rd.s1 = i_rand;
  assign o_done  = done_q;

endmodule

// File: src/masked_shifter.sv
// Five-level shift/rotate of one share, padding with random bits that cancel across shares
`timescale 1ns/10ps
module masked_shifter (
  input  masked_alu_pkg::word_t          i_share,
  input  logic [masked_alu_pkg::SHAMT_W-1:0] i_shamt,
  input  masked_alu_pkg::word_t          i_pad,
  input  masked_alu_pkg::alu_op_e        i_op,
  output masked_alu_pkg::word_t          o_share
);
  import masked_alu_pkg::*;

  word_t lvl;

  always_comb begin
    lvl = i_share;
    // Level k moves by 2**k when its shamt bit is set
    for (int k = 0; k < SHAMT_W; k++) begin
      if (i_shamt[k]) begin
        case (i_op)
          OP_SLL: begin
            lvl = (lvl << (1 << k)) | (i_pad >> (XLEN - (1 << k)));   // Pad low end
          end
          OP_SRL: begin
            lvl = (lvl >> (1 << k)) | (i_pad << (XLEN - (1 << k)));   // Pad high end
          end
          OP_ROR: begin
            lvl = (lvl >> (1 << k)) | (lvl << (XLEN - (1 << k)));
          end
          default: begin
            lvl = lvl;
          end
        endcase
      end
    end
  end

  assign o_share = lvl;

endmodule

// File: src/masked_adder.sv
// Iterative masked Kogge-Stone carry computation, seeded by the logic stage, for add and sub
`timescale 1ns/10ps
module masked_adder (
  input  logic                        g_clk,
  input  logic                        g_resetn,
  input  logic                        i_en,
  input  logic                        i_sub,
  input  masked_alu_pkg::word_t       i_fresh,
  input  masked_alu_pkg::share_pair_t i_xor,
  input  masked_alu_pkg::share_pair_t i_and,
  output masked_alu_pkg::share_pair_t o_sum,
  output logic                        o_done
);
  import masked_alu_pkg::*;

  logic [2:0]         step_q;   // Runs 1 to ADD_STEPS + 1
  logic               first;
  logic               update;
  logic [SHAMT_W-1:0] span;
  word_t              rnd;
  share_pair_t        p_cur, g_cur;
  share_pair_t        p_sh, g_sh;
  share_pair_t        p_q, g_q;
  word_t [3:0]        tg_q, tp_q;

  assign o_done = (step_q == 3'(ADD_STEPS + 1));
  assign first  = i_en && (step_q == 3'd1);
  assign update = i_en && !o_done;
  assign span   = SHAMT_W'(1) << (step_q - 3'd1);   // 1, 2, 4, 8, 16

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      step_q <= 3'd1;
    end else if (o_done) begin
      step_q <= 3'd1;
    end else if (i_en) begin
      step_q <= step_q + 3'd1;
    end
  end

  // First step starts from the logic stage outputs
  assign p_cur   = first ? i_xor : p_q;
  assign g_cur   = first ? i_and : g_q;
  assign rnd     = first ? i_fresh : p_q.s0;
  assign p_sh.s0 = p_cur.s0 << span;
  assign p_sh.s1 = p_cur.s1 << span;
  assign g_sh.s0 = g_cur.s0 << span;
  assign g_sh.s1 = g_cur.s1 << span;

  // G' = G ^ (P & G<<span), P' = P & P<<span, each partial registered on its own
  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      tg_q <= '0;
      tp_q <= '0;
    end else if (update) begin
      tg_q[0] <= g_cur.s0 ^ (g_sh.s0 & p_cur.s0);
      tg_q[1] <= g_cur.s1 ^ (g_sh.s1 & p_cur.s0);
      tg_q[2] <= g_sh.s0 & p_cur.s1;
      tg_q[3] <= g_sh.s1 & p_cur.s1;
      tp_q[0] <= rnd ^ (p_cur.s0 & p_sh.s0);
      tp_q[1] <= rnd ^ (p_cur.s0 & p_sh.s1);
      tp_q[2] <= p_cur.s1 & p_sh.s0;
      tp_q[3] <= p_cur.s1 & p_sh.s1;
    end
  end

  assign g_q.s0 = tg_q[0] ^ tg_q[2];
  assign g_q.s1 = tg_q[1] ^ tg_q[3];
  assign p_q.s0 = tp_q[0] ^ tp_q[2];
  assign p_q.s1 = tp_q[1] ^ tp_q[3];

  // Sum = a ^ b ^ (G << 1), carry-in enters on share 1
  assign o_sum.s0 = o_done ? (i_xor.s0 ^ {g_q.s0[XLEN-2:0], 1'b0}) : '0;
  assign o_sum.s1 = o_done ? (i_xor.s1 ^ {g_q.s1[XLEN-2:0], i_sub}) : '0;

endmodule

// File: src/masked_logic.sv
// Registered threshold masked XOR/AND stage, shared by the logic ops and the adder's first step
`timescale 1ns/10ps
module masked_logic (
  input  logic                        g_clk,
  input  logic                        g_resetn,
  input  logic                        i_en,
  input  masked_alu_pkg::word_t       i_fresh,
  input  masked_alu_pkg::share_pair_t i_a,
  input  masked_alu_pkg::share_pair_t i_b,
  output masked_alu_pkg::share_pair_t o_xor,
  output masked_alu_pkg::share_pair_t o_and,
  output masked_alu_pkg::word_t       o_fresh,
  output logic                        o_ready
);
  import masked_alu_pkg::*;

  share_pair_t xor_q;
  word_t [3:0] t_q;     // AND partial products, kept apart until after the register
  word_t       fresh_q;
  logic        ready_q;

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      xor_q   <= '0;
      t_q     <= '0;
      fresh_q <= '0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= i_en;
      if (i_en) begin
        xor_q.s0 <= i_a.s0 ^ i_b.s0;
        xor_q.s1 <= i_a.s1 ^ i_b.s1;
        t_q[0]   <= i_fresh ^ (i_a.s0 & i_b.s0);
        t_q[1]   <= i_fresh ^ (i_a.s0 & i_b.s1);
        t_q[2]   <= i_a.s1 & i_b.s0;
        t_q[3]   <= i_a.s1 & i_b.s1;
        fresh_q  <= i_a.s1;                      // Uniform share, reused as adder mask
      end
    end
  end

  // Recombine partials per output share, fresh word cancels in the plain value
  assign o_xor    = xor_q;
  assign o_and.s0 = t_q[0] ^ t_q[2];
  assign o_and.s1 = t_q[1] ^ t_q[3];
  assign o_fresh  = fresh_q;
  assign o_ready  = ready_q;

endmodule

// File: src/prng_lfsr.sv
// 32-bit XNOR LFSR giving the masked ALU its masks and fresh random words, stepped per result
`timescale 1ns/10ps
module prng_lfsr (
  input  logic                  g_clk,
  input  logic                  g_resetn,
  input  logic                  i_step,
  output masked_alu_pkg::word_t o_value,
  output masked_alu_pkg::word_t o_next
);
  import masked_alu_pkg::*;

  word_t lfsr_q;
  logic  feedback;

  assign feedback = lfsr_q[31] ~^ lfsr_q[21] ~^ lfsr_q[1] ~^ lfsr_q[0];   // Taps 31, 21, 1, 0
  assign o_next   = {lfsr_q[XLEN-2:0], feedback};
  assign o_value  = lfsr_q;

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      lfsr_q <= LFSR_SEED;
    end else if (i_step) begin
      lfsr_q <= o_next;
    end
  end

endmodule

// File: src/masked_alu_pkg.sv
// Shared word, share and opcode types plus LFSR constants, imported by every masked ALU unit
package masked_alu_pkg;

  localparam int XLEN      = 32;
  localparam int SHAMT_W   = 5;
  localparam int ADD_STEPS = 5;                  // Carry spans 1, 2, 4, 8, 16

  localparam logic [XLEN-1:0] LFSR_SEED = 32'h6789ABCD;

  typedef logic [XLEN-1:0] word_t;

  // Two Boolean shares, plain value is s0 ^ s1
  typedef struct packed {
    word_t s0;
    word_t s1;
  } share_pair_t;

  typedef enum logic [3:0] {
    OP_NOT,
    OP_XOR,
    OP_AND,
    OP_IOR,
    OP_ADD,
    OP_SUB,
    OP_SRL,
    OP_SLL,
    OP_ROR,
    OP_BMASK,
    OP_BREMASK
  } alu_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOGIC,
    ST_ARITH
  } ctl_state_e;

endpackage
